// ==== hw/axil_read_xbar_pkg.sv ====
package axil_read_xbar_pkg;

  // bus widths
  localparam int AXI_ADDR_WIDTH = 20;
  localparam int AXI_DATA_WIDTH = 16;

  // number of managers sharing each subordinate
  localparam int N_MANAGERS = 3;

  // AXI read response code (OKAY, EXOKAY, SLVERR, DECERR)
  typedef logic [1:0] resp_t;

  // which manager holds a channel
  // GRANT_IDLE uses the spare code so it fits in the same two bits
  typedef enum logic [1:0] {
    GRANT_M0   = 2'd0,
    GRANT_M1   = 2'd1,
    GRANT_M2   = 2'd2,
    GRANT_IDLE = 2'd3
  } grant_t;

  // read address channel, manager to subordinate
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic                      valid;
  } ar_chan_t;

  // read data channel, subordinate to manager
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    resp_t                     resp;
    logic                      valid;
  } r_chan_t;

endpackage

// ==== hw/grant_order_fifo.sv ====
`timescale 1ns/1ns

module grant_order_fifo import axil_read_xbar_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic   axi_clk,
  input  logic   axi_resetn,
  input  logic   push,
  input  grant_t push_id,
  input  logic   pop,
  output grant_t head_id,
  output logic   empty,
  output logic   full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  grant_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // id storage, written at the tail slot
  always_ff @(posedge axi_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_id;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_id = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

  // the port holds back AR valid while full, so a push can never land here
  a_no_push_when_full: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    !(push && full));

  // rready is only steered out for a granted response, so no pop without an entry
  a_no_pop_when_empty: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    !(pop && empty));

endmodule

// ==== hw/read_grant_arbiter.sv ====
`timescale 1ns/1ns

module read_grant_arbiter import axil_read_xbar_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  logic [N_MANAGERS-1:0] request,
  input  logic                  accepted,
  input  logic                  completed,
  output grant_t                request_grant,
  output grant_t                response_grant,
  output logic                  order_full
);
  grant_t                next_grant;
  grant_t                head_id;
  logic                  order_empty;
  logic [N_MANAGERS-1:0] served;
  logic [N_MANAGERS-1:0] eligible;
  logic [N_MANAGERS-1:0] pick_from;

  // managers accepted recently stay masked while anyone else is waiting
  assign eligible  = request & ~served;
  assign pick_from = (eligible != '0) ? eligible : request;

  always_comb begin
    next_grant = GRANT_IDLE;
    if (request_grant != GRANT_IDLE) begin
      // hold until the address is taken, then drop to idle for one cycle
      if (!accepted) begin
        next_grant = request_grant;
      end
    end else if (pick_from[0]) begin
      next_grant = GRANT_M0;
    end else if (pick_from[1]) begin
      next_grant = GRANT_M1;
    end else if (pick_from[2]) begin
      next_grant = GRANT_M2;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      request_grant <= GRANT_IDLE;
      served        <= '0;
    end else begin
      request_grant <= next_grant;
      if (accepted) begin
        served <= served | (N_MANAGERS'(1) << request_grant);
      end else if (request_grant == GRANT_IDLE && eligible == '0) begin
        // every waiting manager had its turn, start over at fixed priority
        served <= '0;
      end
    end
  end

  // accepted ids wait here until their read data has been returned
  grant_order_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) order_fifo (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .push      (accepted),
    .push_id   (request_grant),
    .pop       (completed),
    .head_id   (head_id),
    .empty     (order_empty),
    .full      (order_full)
  );

  assign response_grant = order_empty ? GRANT_IDLE : head_id;

  // a held grant may only move once its address has been handed over
  a_grant_held: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (request_grant != GRANT_IDLE && !accepted) |=> $stable(request_grant));

endmodule

// ==== hw/subordinate_read_port.sv ====
`timescale 1ns/1ns

module subordinate_read_port import axil_read_xbar_pkg::*; #(
  parameter logic ADDR_PARITY = 1'b0,
  parameter int   FIFO_DEPTH  = 4
) (
  input  logic                             axi_clk,
  input  logic                             axi_resetn,
  input  ar_chan_t [N_MANAGERS-1:0]        mgr_ar,
  input  logic     [N_MANAGERS-1:0]        mgr_rready,
  output logic     [N_MANAGERS-1:0]        arready_to_mgr,
  output r_chan_t  [N_MANAGERS-1:0]        r_to_mgr,
  output ar_chan_t                         sub_ar,
  input  logic                             sub_arready,
  input  r_chan_t                          sub_r,
  output logic                             sub_rready
);
  logic [N_MANAGERS-1:0] request;
  logic                  accepted;
  logic                  completed;
  logic                  order_full;
  grant_t                request_grant;
  grant_t                response_grant;

  // a manager competes for this port when its address parity matches
  always_comb begin
    for (int i = 0; i < N_MANAGERS; i++) begin
      request[i] = mgr_ar[i].valid && (mgr_ar[i].addr[0] == ADDR_PARITY);
    end
  end

  read_grant_arbiter #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) arbiter (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .request       (request),
    .accepted      (accepted),
    .completed     (completed),
    .request_grant (request_grant),
    .response_grant(response_grant),
    .order_full    (order_full)
  );

  // AR path follows the request grant
  // with the order FIFO full, nothing is offered and arready is kept from the manager
  always_comb begin
    sub_ar         = '0;
    arready_to_mgr = '0;
    if (request_grant != GRANT_IDLE && !order_full) begin
      sub_ar                        = mgr_ar[request_grant];
      arready_to_mgr[request_grant] = sub_arready;
    end
  end

  assign accepted = sub_ar.valid && sub_arready;

  // R path follows the oldest outstanding grant
  always_comb begin
    r_to_mgr   = '0;
    sub_rready = 1'b0;
    if (response_grant != GRANT_IDLE) begin
      r_to_mgr[response_grant] = sub_r;
      sub_rready               = mgr_rready[response_grant];
    end
  end

  assign completed = sub_r.valid && sub_rready;

endmodule

// ==== hw/manager_response_merge.sv ====
`timescale 1ns/1ns

module manager_response_merge import axil_read_xbar_pkg::*; (
  input  logic                           axi_clk,
  input  logic                           axi_resetn,
  input  logic    [N_MANAGERS-1:0]       port0_arready,
  input  logic    [N_MANAGERS-1:0]       port1_arready,
  input  r_chan_t [N_MANAGERS-1:0]       port0_r,
  input  r_chan_t [N_MANAGERS-1:0]       port1_r,
  output logic    [N_MANAGERS-1:0]       mgr_arready,
  output r_chan_t [N_MANAGERS-1:0]       mgr_r
);
  // a manager's address targets one port only, so the readies never overlap
  assign mgr_arready = port0_arready | port1_arready;

  // idle ports drive zeros, so falling back to port 1 is safe
  always_comb begin
    for (int i = 0; i < N_MANAGERS; i++) begin
      mgr_r[i] = port0_r[i].valid ? port0_r[i] : port1_r[i];
    end
  end

  // both subordinates may hold reads for one manager, but the ports
  // must never return data to it in the same cycle
  for (genvar i = 0; i < N_MANAGERS; i++) begin : g_check
    a_single_source: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      !(port0_r[i].valid && port1_r[i].valid));
  end

endmodule

// ==== hw/axil_read_xbar.sv ====
`timescale 1ns/1ns

module axil_read_xbar import axil_read_xbar_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       axi_clk,
  input  logic                       axi_resetn,

  // manager side
  input  ar_chan_t [N_MANAGERS-1:0]  mgr_ar,
  output logic     [N_MANAGERS-1:0]  mgr_arready,
  output r_chan_t  [N_MANAGERS-1:0]  mgr_r,
  input  logic     [N_MANAGERS-1:0]  mgr_rready,

  // subordinate side, 0 takes even addresses and 1 takes odd
  output ar_chan_t [1:0]             sub_ar,
  input  logic     [1:0]             sub_arready,
  input  r_chan_t  [1:0]             sub_r,
  output logic     [1:0]             sub_rready
);
  logic    [1:0][N_MANAGERS-1:0] port_arready;
  r_chan_t [1:0][N_MANAGERS-1:0] port_r;

  for (genvar s = 0; s < 2; s++) begin : g_port
    subordinate_read_port #(
      .ADDR_PARITY(1'(s)),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) port (
      .axi_clk       (axi_clk),
      .axi_resetn    (axi_resetn),
      .mgr_ar        (mgr_ar),
      .mgr_rready    (mgr_rready),
      .arready_to_mgr(port_arready[s]),
      .r_to_mgr      (port_r[s]),
      .sub_ar        (sub_ar[s]),
      .sub_arready   (sub_arready[s]),
      .sub_r         (sub_r[s]),
      .sub_rready    (sub_rready[s])
    );
  end

  manager_response_merge merge (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .port0_arready(port_arready[0]),
    .port1_arready(port_arready[1]),
    .port0_r      (port_r[0]),
    .port1_r      (port_r[1]),
    .mgr_arready  (mgr_arready),
    .mgr_r        (mgr_r)
  );

endmodule

// ==== testbench/tb_axil_read_xbar.sv ====
`timescale 1ns/1ns

module tb_axil_read_xbar import axil_read_xbar_pkg::*;;
  localparam int CLK_PERIOD = 40;
  // about 55 reads and none needs more than 25 cycles even when queued behind others
  localparam int MAX_CYCLES = 1500;
  localparam int LOG_DEPTH  = 256;

  logic                      axi_clk     = 1'b0;
  logic                      axi_resetn  = 1'b0;
  ar_chan_t [N_MANAGERS-1:0] mgr_ar      = '0;
  logic     [N_MANAGERS-1:0] mgr_rready  = '0;
  logic     [1:0]            sub_arready = '0;
  r_chan_t  [1:0]            sub_r       = '0;
  logic     [N_MANAGERS-1:0] mgr_arready;
  r_chan_t  [N_MANAGERS-1:0] mgr_r;
  ar_chan_t [1:0]            sub_ar;
  logic     [1:0]            sub_rready;

  // manager models with queued requests, expected returns and handshake logs
  logic [AXI_ADDR_WIDTH-1:0] req_addr [N_MANAGERS][LOG_DEPTH];
  logic [AXI_ADDR_WIDTH-1:0] exp_addr [N_MANAGERS][LOG_DEPTH];
  int                        req_wr [N_MANAGERS];
  int                        req_rd [N_MANAGERS];
  int                        exp_wr [N_MANAGERS];
  int                        exp_rd [N_MANAGERS];
  int                        outstanding [N_MANAGERS];
  int                        acc_log [LOG_DEPTH];
  int                        resp_log [LOG_DEPTH];
  int                        acc_n  = 0;
  int                        resp_n = 0;
  logic [N_MANAGERS-1:0]     ar_taken;
  logic [N_MANAGERS-1:0]     r_waiting   = '0;
  r_chan_t [N_MANAGERS-1:0]  r_prev;
  logic [N_MANAGERS-1:0]     hold_rready = '0;
  logic                      wait_resp   = 1'b0;
  logic                      rand_rready = 1'b0;
  logic [AXI_ADDR_WIDTH-1:0] expected_addr;
  int                        sub_hs;
  int                        mgr_hs;

  // subordinate models
  logic [AXI_ADDR_WIDTH-1:0] pend_addr [2][LOG_DEPTH];
  logic [AXI_ADDR_WIDTH-1:0] last_addr [2];
  int                        pend_wr [2];
  int                        pend_rd [2];
  int                        wait_cnt [2];
  int                        ar_delay [2];

  int                        mon_mismatch  = 0;
  int                        mon_other     = 0;
  int                        test_mismatch = 0;
  int                        test_other    = 0;
  int                        cycle_count   = 0;
  int unsigned               seed_value;

  axil_read_xbar #(
    .FIFO_DEPTH(4)
  ) DUT (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .mgr_ar     (mgr_ar),
    .mgr_arready(mgr_arready),
    .mgr_r      (mgr_r),
    .mgr_rready (mgr_rready),
    .sub_ar     (sub_ar),
    .sub_arready(sub_arready),
    .sub_r      (sub_r),
    .sub_rready (sub_rready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) axi_clk = ~axi_clk;
  end

  // data a manager expects from the subordinate its address parity selects
  function automatic logic [AXI_DATA_WIDTH-1:0] expected_data(
    input logic [AXI_ADDR_WIDTH-1:0] addr
  );
    return addr[15:0] ^ (addr[0] ? 16'hA500 : 16'h5A00);
  endfunction

  // manager models and response checks
  always @(posedge axi_clk) begin
    ar_taken = '0;
    if (axi_resetn) begin
      sub_hs = 0;
      mgr_hs = 0;
      for (int m = 0; m < N_MANAGERS; m++) begin
        if (r_waiting[m]) begin
          assert (mgr_r[m] == r_prev[m])
            else begin
              mon_mismatch++;
              $display("mismatch: mgr_r[%0d] = %h while stalled, expected %h", m, mgr_r[m],
                       r_prev[m]);
            end
        end
        r_waiting[m] = mgr_r[m].valid && !mgr_rready[m];
        r_prev[m]    = mgr_r[m];
        if (mgr_ar[m].valid && mgr_arready[m]) begin
          ar_taken[m] = 1'b1;
          exp_addr[m][exp_wr[m]] = mgr_ar[m].addr;
          exp_wr[m]++;
          outstanding[m]++;
          acc_log[acc_n] = m;
          acc_n++;
        end
        if (mgr_r[m].valid && mgr_rready[m]) begin
          mgr_hs++;
          resp_log[resp_n] = m;
          resp_n++;
          assert (exp_rd[m] != exp_wr[m])
            else begin
              mon_other++;
              $display("manager %0d received read data with no read outstanding", m);
            end
          expected_addr = exp_addr[m][exp_rd[m]];
          exp_rd[m]++;
          outstanding[m]--;
          assert (mgr_r[m].data == expected_data(expected_addr) && mgr_r[m].resp == 2'b00)
            else begin
              mon_mismatch++;
              $display("mismatch: mgr_r[%0d] data/resp = %h/%h, expected %h/0", m,
                       mgr_r[m].data, mgr_r[m].resp, expected_data(expected_addr));
            end
        end
      end
      for (int s = 0; s < 2; s++) begin
        if (sub_ar[s].valid && sub_arready[s]) begin
          assert (sub_ar[s].addr[0] == (s == 1))
            else begin
              mon_other++;
              $display("subordinate %0d was sent address %h of the wrong parity", s,
                       sub_ar[s].addr);
            end
        end
        if (sub_r[s].valid && sub_rready[s]) begin
          sub_hs++;
        end
      end
      // a response routed to two places at once would show up as a count difference
      assert (sub_hs == mgr_hs)
        else begin
          mon_other++;
          $display("subordinates completed %0d reads but managers took %0d", sub_hs, mgr_hs);
        end
    end
    #5;
    for (int m = 0; m < N_MANAGERS; m++) begin
      if (ar_taken[m] || !mgr_ar[m].valid) begin
        mgr_ar[m].valid = 1'b0;
        if (req_rd[m] != req_wr[m] && (!wait_resp || outstanding[m] == 0)) begin
          mgr_ar[m].addr  = req_addr[m][req_rd[m]];
          mgr_ar[m].valid = 1'b1;
          req_rd[m]++;
        end
      end
      mgr_rready[m] = !hold_rready[m] && (!rand_rready || ($urandom % 3 != 0));
    end
  end

  // subordinate models answer one read at a time in acceptance order
  always @(posedge axi_clk) begin
    if (axi_resetn) begin
      for (int s = 0; s < 2; s++) begin
        if (sub_ar[s].valid && sub_arready[s]) begin
          pend_addr[s][pend_wr[s]] = sub_ar[s].addr;
          pend_wr[s]++;
          last_addr[s] = sub_ar[s].addr;
          wait_cnt[s]  = 0;
        end else if (sub_ar[s].valid) begin
          wait_cnt[s]++;
        end
        if (sub_r[s].valid && sub_rready[s]) begin
          pend_rd[s]++;
        end
      end
    end
    #5;
    for (int s = 0; s < 2; s++) begin
      sub_arready[s] = (wait_cnt[s] >= ar_delay[s]);
      sub_r[s] = '0;
      if (pend_rd[s] != pend_wr[s]) begin
        // subordinate 0 keys its data with 5A00 and subordinate 1 with A500
        sub_r[s].data  = pend_addr[s][pend_rd[s]][AXI_DATA_WIDTH-1:0] ^
                         ((s == 0) ? 16'h5A00 : 16'hA500);
        sub_r[s].valid = 1'b1;
      end
    end
  end

  always @(posedge axi_clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d mismatches, %0d other failures", mon_mismatch + test_mismatch,
               mon_other + test_other + 1);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge axi_clk);
    #1;
  endtask

  task automatic issue_read(input int m, input logic [AXI_ADDR_WIDTH-1:0] addr);
    req_addr[m][req_wr[m]] = addr;
    req_wr[m]++;
  endtask

  function automatic logic reads_pending();
    logic busy;
    busy = 1'b0;
    for (int m = 0; m < N_MANAGERS; m++) begin
      busy |= (req_rd[m] != req_wr[m]) || (outstanding[m] != 0) || mgr_ar[m].valid;
    end
    return busy;
  endfunction

  task automatic wait_until_idle();
    next_cycle();
    while (reads_pending()) begin
      next_cycle();
    end
  endtask

  task automatic wait_for_accepts(input int target);
    while (acc_n < target) begin
      next_cycle();
    end
  endtask

  task automatic check_reset_state();
    next_cycle();
    assert (mgr_arready == '0 && sub_rready == '0)
      else begin
        test_mismatch++;
        $display("mismatch: mgr_arready/sub_rready = %h/%h, expected 0/0", mgr_arready,
                 sub_rready);
      end
    for (int m = 0; m < N_MANAGERS; m++) begin
      assert (!mgr_r[m].valid)
        else begin
          test_mismatch++;
          $display("mismatch: mgr_r[%0d].valid = %h, expected 0", m, mgr_r[m].valid);
        end
    end
    for (int s = 0; s < 2; s++) begin
      assert (!sub_ar[s].valid)
        else begin
          test_mismatch++;
          $display("mismatch: sub_ar[%0d].valid = %h, expected 0", s, sub_ar[s].valid);
        end
    end
  endtask

  task automatic check_routing();
    logic [AXI_ADDR_WIDTH-1:0] addr;
    ar_delay[0] = 1;
    ar_delay[1] = 2;
    for (int m = 0; m < N_MANAGERS; m++) begin
      for (int p = 0; p < 2; p++) begin
        addr = 20'h5A6C0 + 20'(m) * 20'h01010 + 20'(p);
        issue_read(m, addr);
        wait_until_idle();
        assert (last_addr[p] == addr)
          else begin
            test_mismatch++;
            $display("mismatch: sub_ar[%0d].addr = %h, expected %h", p, last_addr[p], addr);
          end
      end
    end
  endtask

  task automatic check_arbitration_order();
    int start;
    int expected_order [4];
    start = acc_n;
    expected_order = '{0, 1, 2, 0};
    ar_delay[0] = 0;
    // manager 0 queues a second read that goes out right after its first is taken
    issue_read(0, 20'h10A40);
    issue_read(0, 20'h10A42);
    issue_read(1, 20'h20B64);
    issue_read(2, 20'h30C86);
    wait_until_idle();
    for (int i = 0; i < 4; i++) begin
      assert (acc_log[start + i] == expected_order[i])
        else begin
          test_mismatch++;
          $display("mismatch: accept slot %0d = manager %h, expected manager %h", i,
                   acc_log[start + i], expected_order[i]);
        end
    end
  endtask

  task automatic check_parallel_reads();
    int acc_start;
    ar_delay[0] = 1;
    ar_delay[1] = 1;
    acc_start = acc_n;
    issue_read(0, 20'h4D2E8);
    issue_read(1, 20'h6F1A3);
    wait_for_accepts(acc_start + 1);
    // each port has its own arbiter, so both addresses are taken on the same edge
    assert (acc_n == acc_start + 2)
      else begin
        test_other++;
        $display("the reads of managers 0 and 1 were not accepted in the same cycle");
      end
    wait_until_idle();
  endtask

  task automatic check_backpressure();
    int acc_start;
    int resp_start;
    int expected_order [3];
    ar_delay[0] = 0;
    acc_start  = acc_n;
    resp_start = resp_n;
    expected_order = '{2, 0, 1};
    hold_rready[2] = 1'b1;
    issue_read(2, 20'h7E550);
    wait_for_accepts(acc_start + 1);
    issue_read(0, 20'h81F12);
    issue_read(1, 20'h92A34);
    wait_for_accepts(acc_start + 3);
    // manager 2 keeps stalling while the monitor watches its data
    repeat (6) next_cycle();
    assert (resp_n == resp_start && mgr_r[2].valid)
      else begin
        test_other++;
        $display("a read completed while manager 2 held back the oldest response");
      end
    hold_rready[2] = 1'b0;
    wait_until_idle();
    for (int i = 0; i < 3; i++) begin
      assert (resp_log[resp_start + i] == expected_order[i])
        else begin
          test_mismatch++;
          $display("mismatch: response slot %0d = manager %h, expected manager %h", i,
                   resp_log[resp_start + i], expected_order[i]);
        end
    end
  endtask

  task automatic check_random_traffic();
    int m;
    ar_delay[0] = $urandom % 3;
    ar_delay[1] = $urandom % 3;
    wait_resp   = 1'b1;
    rand_rready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      m = $urandom % 3;
      issue_read(m, AXI_ADDR_WIDTH'($urandom));
    end
    wait_until_idle();
    wait_resp   = 1'b0;
    rand_rready = 1'b0;
  endtask

  initial begin
    seed_value = $urandom(33780);
    repeat (2) @(posedge axi_clk);
    #5 axi_resetn = 1'b1;
    check_reset_state();
    check_routing();
    check_arbitration_order();
    check_parallel_reads();
    check_backpressure();
    check_random_traffic();
    repeat (2) next_cycle();
    $display("errors: %0d mismatches, %0d other failures", mon_mismatch + test_mismatch,
             mon_other + test_other);
    if (mon_mismatch + test_mismatch + mon_other + test_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for a failure
rm -f sim.log
verilator --binary --timing --assert --top-module tb_axil_read_xbar -f project.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== project.f ====
hw/axil_read_xbar_pkg.sv
hw/grant_order_fifo.sv
hw/read_grant_arbiter.sv
hw/subordinate_read_port.sv
hw/manager_response_merge.sv
hw/axil_read_xbar.sv
testbench/tb_axil_read_xbar.sv
